// File: rx_subsystem_top.f
source/rx_packet_pkg.sv
source/rx_line_conditioner.sv
source/uart_packet_rx.sv
source/packet_collector.sv
source/rx_subsystem_top.sv
verif/rx_subsystem_tb.sv

// File: source/packet_collector.sv
// round-robin unloader over all lane receivers that decodes each word into a one-cycle output strobe
module packet_collector (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  rx_packet_pkg::packet_word_u             rx_word [rx_packet_pkg::num_lanes],
    input  logic [rx_packet_pkg::num_lanes-1:0]     rx_empty,
    input  logic [rx_packet_pkg::num_lanes-1:0]     rx_parity_error,
    output logic [rx_packet_pkg::num_lanes-1:0]     unload,
    output logic                                    pkt_valid,
    output logic [rx_packet_pkg::lane_idx_bits-1:0] pkt_lane,
    output rx_packet_pkg::packet_word_u             pkt_word,
    output logic                                    pkt_parity_error,
    output logic                                    pkt_is_config,
    output logic [31:0]                             pkt_timestamp,
    output logic [7:0]                              pkt_reg_addr,
    output logic [31:0]                             pkt_reg_value
);
    import rx_packet_pkg::*;

    // last granted lane and the lane under unload while unload is up
    logic [lane_idx_bits-1:0] last_lane;
    // full lanes not already being unloaded
    logic [num_lanes-1:0]     pending;
    logic                     grant;
    logic [lane_idx_bits-1:0] grant_lane;
    logic [lane_idx_bits-1:0] cand;
    // word of the lane under unload
    packet_word_u             sel_word;
    logic                     sel_is_config;

    ////////////////////////////////////////////////////////////////////////////
    // round-robin pick
    ////////////////////////////////////////////////////////////////////////////

    // scan upward from the lane after last_lane and wrap around
    always_comb begin
        pending    = ~rx_empty & ~unload;
        grant      = 1'b0;
        grant_lane = last_lane;
        cand       = last_lane;
        for (int k = 1; k <= num_lanes; k++) begin
            cand = lane_idx_bits'((int'(last_lane) + k) % num_lanes);
            if (!grant && pending[cand]) begin
                grant      = 1'b1;
                grant_lane = cand;
            end
        end
    end

    // one unload pulse per cycle at most
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            unload    <= '0;
            // so lane 0 is served first
            last_lane <= lane_idx_bits'(num_lanes - 1);
            pkt_valid <= 1'b0;
        end else begin
            unload <= '0;
            if (grant) begin
                unload[grant_lane] <= 1'b1;
                last_lane          <= grant_lane;
            end
            // word captured during the unload cycle
            pkt_valid <= |unload;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode and output register
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_word      = rx_word[last_lane];
        sel_is_config = 1'b0;
        case (sel_word.cfg_view.kind)
            kind_data:      sel_is_config = 1'b0;
            kind_test:      sel_is_config = 1'b0;
            kind_cfg_write: sel_is_config = 1'b1;
            kind_cfg_read:  sel_is_config = 1'b1;
            default:        sel_is_config = 1'b0;
        endcase
    end

    // rx_word is still held because rx_empty only rises after this edge
    always_ff @(posedge clk) begin
        if (|unload) begin
            pkt_lane         <= last_lane;
            pkt_word         <= sel_word;
            pkt_parity_error <= rx_parity_error[last_lane];
            pkt_is_config    <= sel_is_config;
            // fields of the view that does not apply read as zero
            if (sel_is_config) begin
                pkt_timestamp <= '0;
                pkt_reg_addr  <= sel_word.cfg_view.reg_addr;
                pkt_reg_value <= sel_word.cfg_view.reg_value;
            end else begin
                pkt_timestamp <= sel_word.data_view.timestamp;
                pkt_reg_addr  <= '0;
                pkt_reg_value <= '0;
            end
        end
    end

    // a lane under unload is not granted again on the next cycle
    a_unload_no_repeat: assert property (@(posedge clk) disable iff (!reset_n)
        (unload & $past(unload)) == '0)
        else $error("lane unloaded in two consecutive cycles");

endmodule

// File: source/rx_line_conditioner.sv
// brings every serial lane into the clk domain and masks lanes that stay low too long
module rx_line_conditioner (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [rx_packet_pkg::num_lanes-1:0] serial_in,
    output logic [rx_packet_pkg::num_lanes-1:0] line_clean,
    output logic [rx_packet_pkg::num_lanes-1:0] lane_fault
);
    import rx_packet_pkg::*;

    // two-flop synchronizer with both stages reset to idle high
    logic [num_lanes-1:0] sync_1;
    logic [num_lanes-1:0] sync_2;
    // low-run length per lane that saturates at stuck_limit
    logic [stuck_cnt_bits-1:0] low_run [num_lanes];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_1 <= '1;
            sync_2 <= '1;
            for (int i = 0; i < num_lanes; i++) begin
                low_run[i] <= '0;
            end
        end else begin
            sync_1 <= serial_in;
            sync_2 <= sync_1;
            for (int i = 0; i < num_lanes; i++) begin
                // any high sample restarts the run
                if (sync_2[i]) begin
                    low_run[i] <= '0;
                end else if (low_run[i] != stuck_cnt_bits'(stuck_limit)) begin
                    low_run[i] <= low_run[i] + 1'b1;
                end
            end
        end
    end

    // fault drops on the first high sample itself
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_fault[i] = (low_run[i] == stuck_cnt_bits'(stuck_limit)) && !sync_2[i];
        end
    end

    // a faulted lane looks idle to its receiver
    assign line_clean = sync_2 | lane_fault;

    // a fault needs stuck_limit low samples before the current one
    a_fault_after_run: assert property (@(posedge clk) disable iff (!reset_n)
        (lane_fault & $past(sync_2, stuck_limit)) == '0)
        else $error("lane fault without a full low run");

endmodule

// File: source/rx_packet_pkg.sv
// shared constants and packet word views for the serial readout receive path; import where needed
package rx_packet_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // lane and frame sizes
    ////////////////////////////////////////////////////////////////////////////

    // number of front-end serial lanes
    localparam int num_lanes = 4;
    localparam int lane_idx_bits = 2;

    // bits following the start bit, parity included
    localparam int packet_bits = 64;
    // payload only, parity stripped
    localparam int word_bits = 63;

    // receiver bit counter runs 0..packet_bits+1
    localparam int bit_cnt_bits = $clog2(packet_bits + 2);

    // consecutive low samples that mark a stuck lane
    // longest legal low run is 65, so 72 leaves margin
    localparam int stuck_limit = 72;
    localparam int stuck_cnt_bits = $clog2(stuck_limit + 1);

    ////////////////////////////////////////////////////////////////////////////
    // packet declaration codes, bits 1:0 of every word
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [1:0] kind_data      = 2'd0;
    localparam logic [1:0] kind_test      = 2'd1;
    localparam logic [1:0] kind_cfg_write = 2'd2;
    localparam logic [1:0] kind_cfg_read  = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // word views, listed msb first
    ////////////////////////////////////////////////////////////////////////////

    // data and test packets
    typedef struct packed {
        logic        downstream;          // 62
        logic [1:0]  shared_fifo_status;  // 61:60 full, half full
        logic [1:0]  local_fifo_status;   // 59:58 full, half full
        logic [1:0]  trigger_type;        // 57:56 normal, ext, cross, periodic
        logic [7:0]  adc_data;            // 55:48
        logic [31:0] timestamp;           // 47:16
        logic [5:0]  channel_id;          // 15:10
        logic [7:0]  chip_id;             // 9:2
        logic [1:0]  kind;                // 1:0
    } packet_data_view_t;

    // configuration write and read packets
    typedef struct packed {
        logic        downstream;          // 62
        logic [5:0]  reserved;            // 61:56
        logic [31:0] reg_value;           // 55:24
        logic [7:0]  reg_addr;            // 23:16
        logic [5:0]  channel_id;          // 15:10
        logic [7:0]  chip_id;             // 9:2
        logic [1:0]  kind;                // 1:0
    } packet_cfg_view_t;

    // one received word, decoded by kind
    typedef union packed {
        packet_data_view_t data_view;
        packet_cfg_view_t  cfg_view;
    } packet_word_u;

endpackage

// File: source/rx_subsystem_top.sv
// readout receive subsystem, serial lanes in and decoded packet strobes out
module rx_subsystem_top (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic [rx_packet_pkg::num_lanes-1:0]     serial_in,
    output logic [rx_packet_pkg::num_lanes-1:0]     lane_fault,
    output logic                                    pkt_valid,
    output logic [rx_packet_pkg::lane_idx_bits-1:0] pkt_lane,
    output rx_packet_pkg::packet_word_u             pkt_word,
    output logic                                    pkt_parity_error,
    output logic                                    pkt_is_config,
    output logic [31:0]                             pkt_timestamp,
    output logic [7:0]                              pkt_reg_addr,
    output logic [31:0]                             pkt_reg_value
);
    import rx_packet_pkg::*;

    // conditioned lane samples
    logic [num_lanes-1:0] line_clean;
    // receiver to collector
    packet_word_u         rx_word [num_lanes];
    logic [num_lanes-1:0] rx_empty;
    logic [num_lanes-1:0] rx_parity_error;
    logic [num_lanes-1:0] unload;

    rx_line_conditioner u_cond (
        .clk        (clk),
        .reset_n    (reset_n),
        .serial_in  (serial_in),
        .line_clean (line_clean),
        .lane_fault (lane_fault)
    );

    // one receiver per lane
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        uart_packet_rx u_rx (
            .clk             (clk),
            .reset_n         (reset_n),
            .line            (line_clean[i]),
            .unload          (unload[i]),
            .rx_word         (rx_word[i]),
            .rx_empty        (rx_empty[i]),
            .rx_parity_error (rx_parity_error[i])
        );
    end

    packet_collector u_coll (
        .clk              (clk),
        .reset_n          (reset_n),
        .rx_word          (rx_word),
        .rx_empty         (rx_empty),
        .rx_parity_error  (rx_parity_error),
        .unload           (unload),
        .pkt_valid        (pkt_valid),
        .pkt_lane         (pkt_lane),
        .pkt_word         (pkt_word),
        .pkt_parity_error (pkt_parity_error),
        .pkt_is_config    (pkt_is_config),
        .pkt_timestamp    (pkt_timestamp),
        .pkt_reg_addr     (pkt_reg_addr),
        .pkt_reg_value    (pkt_reg_value)
    );

endmodule

// File: source/uart_packet_rx.sv
// one-lane serial packet receiver that holds a word until the collector unloads it
module uart_packet_rx (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        line,
    input  logic                        unload,
    output rx_packet_pkg::packet_word_u rx_word,
    output logic                        rx_empty,
    output logic                        rx_parity_error
);
    import rx_packet_pkg::*;

    // frame in progress
    logic busy;
    // counts 1..packet_bits while sampling and packet_bits+1 on the stop cycle
    logic [bit_cnt_bits-1:0] bit_cnt;
    // previous line sample for start edge detection
    logic line_q;
    // incoming bits enter at the msb because the wire sends lsb first
    logic [packet_bits-1:0] rx_shift;
    logic frame_done;
    logic shift_en;

    assign frame_done = busy && (bit_cnt == bit_cnt_bits'(packet_bits + 1));
    assign shift_en   = busy && !frame_done;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy            <= 1'b0;
            bit_cnt         <= '0;
            line_q          <= 1'b1;
            rx_empty        <= 1'b1;
            rx_parity_error <= 1'b0;
        end else begin
            line_q <= line;
            if (unload) begin
                rx_empty <= 1'b1;
            end
            // start bit needs a high sample before it
            // so a lane stuck low past its stop slot never restarts
            if (!busy && !line && line_q) begin
                busy    <= 1'b1;
                bit_cnt <= bit_cnt_bits'(1);
            end
            if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // the stop slot completes the word and overrides a same-cycle unload
            if (frame_done) begin
                busy     <= 1'b0;
                bit_cnt  <= '0;
                rx_empty <= 1'b0;
                // parity bit must make the total count of ones odd
                rx_parity_error <= rx_shift[packet_bits-1] != ~^rx_shift[word_bits-1:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (shift_en) begin
            rx_shift <= {line, rx_shift[packet_bits-1:1]};
        end
        if (frame_done) begin
            rx_word <= rx_shift[word_bits-1:0];
        end
    end

    a_unload_full: assert property (@(posedge clk) disable iff (!reset_n)
        unload |-> !rx_empty)
        else $error("unload while receiver is empty");

    // the held word must be taken before the next frame completes
    a_no_overwrite: assert property (@(posedge clk) disable iff (!reset_n)
        frame_done |-> (rx_empty || unload))
        else $error("held word overwritten before unload");

endmodule

// File: verif/rx_subsystem_tb.sv
// table-driven testbench for the serial readout receive subsystem, run as the simulation top
module rx_subsystem_tb;
    import rx_packet_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // delay counts falling edges after the previous row was launched
    typedef struct packed {
        int         lane;
        logic [1:0] kind;
        int         delay;
        logic       corrupt;
        logic       stuck;
    } row_t;

    localparam int num_rows = 16;
    // longest row budget plus drain margin
    localparam int timeout_cycles = num_rows * 80 + 200;

    row_t table_rows [num_rows] = '{
        '{0, kind_data,      2,  1'b0, 1'b0},
        '{1, kind_cfg_write, 0,  1'b0, 1'b0},
        '{2, kind_cfg_read,  5,  1'b0, 1'b0},
        '{3, kind_test,      7,  1'b0, 1'b0},
        '{1, kind_data,      90, 1'b1, 1'b0},
        // all four lanes start in the same cycle
        '{0, kind_data,      90, 1'b0, 1'b0},
        '{1, kind_test,      0,  1'b0, 1'b0},
        '{2, kind_cfg_write, 0,  1'b0, 1'b0},
        '{3, kind_cfg_read,  0,  1'b1, 1'b0},
        // lane 2 held low, then a normal frame on it
        '{2, kind_data,      90, 1'b0, 1'b1},
        '{2, kind_data,      0,  1'b0, 1'b0},
        '{3, kind_data,      0,  1'b1, 1'b0},
        // back to back on lane 1, one stop cycle apart
        '{1, kind_data,      20, 1'b0, 1'b0},
        '{1, kind_cfg_write, 0,  1'b0, 1'b0},
        '{1, kind_test,      0,  1'b1, 1'b0},
        '{0, kind_cfg_read,  30, 1'b0, 1'b0}
    };

    ////////////////////////////////////////////////////////////////////////////
    // DUT and clock
    ////////////////////////////////////////////////////////////////////////////

    logic                     clk = 1'b0;
    logic                     reset_n;
    logic [num_lanes-1:0]     serial_in;
    logic [num_lanes-1:0]     lane_fault;
    logic                     pkt_valid;
    logic [lane_idx_bits-1:0] pkt_lane;
    packet_word_u             pkt_word;
    logic                     pkt_parity_error;
    logic                     pkt_is_config;
    logic [31:0]              pkt_timestamp;
    logic [7:0]               pkt_reg_addr;
    logic [31:0]              pkt_reg_value;

    // bits still to be driven, one queue per lane
    logic         bit_q [num_lanes][$];
    // expected packets per lane, arrival order between lanes is free
    packet_word_u exp_word_q [num_lanes][$];
    logic         exp_perr_q [num_lanes][$];
    logic [num_lanes-1:0] stuck_active;
    logic [num_lanes-1:0] fault_seen;
    int           cycle_cnt;
    logic [31:0]  rng_state;

    always #20 clk = ~clk;

    rx_subsystem_top dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .serial_in        (serial_in),
        .lane_fault       (lane_fault),
        .pkt_valid        (pkt_valid),
        .pkt_lane         (pkt_lane),
        .pkt_word         (pkt_word),
        .pkt_parity_error (pkt_parity_error),
        .pkt_is_config    (pkt_is_config),
        .pkt_timestamp    (pkt_timestamp),
        .pkt_reg_addr     (pkt_reg_addr),
        .pkt_reg_value    (pkt_reg_value)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input packet_word_u got, input packet_word_u exp);
        if (got !== exp)
            fail_stop($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_lane(input string name, input logic [lane_idx_bits-1:0] got,
                              input logic [lane_idx_bits-1:0] exp);
        if (got !== exp)
            fail_stop($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_stop($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_stop($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fill the view that matches the kind, everything else stays zero
    function automatic packet_word_u make_word(input logic [1:0] kind, input logic [31:0] r1,
                                               input logic [31:0] r2, input logic [31:0] r3);
        packet_word_u w;
        w = '0;
        if (kind == kind_cfg_write || kind == kind_cfg_read) begin
            w.cfg_view.kind       = kind;
            w.cfg_view.chip_id    = r1[7:0];
            w.cfg_view.channel_id = r1[13:8];
            w.cfg_view.downstream = r1[14];
            w.cfg_view.reg_addr   = r2[7:0];
            w.cfg_view.reg_value  = r3;
        end else begin
            w.data_view.kind               = kind;
            w.data_view.chip_id            = r1[7:0];
            w.data_view.channel_id         = r1[13:8];
            w.data_view.downstream         = r1[14];
            w.data_view.timestamp          = r2;
            w.data_view.adc_data           = r3[7:0];
            w.data_view.trigger_type       = r3[9:8];
            w.data_view.local_fifo_status  = r3[11:10];
            w.data_view.shared_fifo_status = r3[13:12];
        end
        return w;
    endfunction

    // start, 63 bits lsb first, odd parity, one stop bit
    task automatic send_frame(input int lane, input packet_word_u word, input logic corrupt);
        logic parity;
        parity = ~^word;
        if (corrupt)
            parity = ~parity;
        bit_q[lane].push_back(1'b0);
        for (int b = 0; b < word_bits; b++) begin
            bit_q[lane].push_back(word[b]);
        end
        bit_q[lane].push_back(parity);
        bit_q[lane].push_back(1'b1);
        exp_word_q[lane].push_back(word);
        exp_perr_q[lane].push_back(corrupt);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle monitor and driver
    ////////////////////////////////////////////////////////////////////////////

    // match on the head word of any lane, so pkt_lane is checked independently
    task automatic check_packet();
        int           lane;
        packet_word_u exp_word;
        logic         exp_perr;
        logic         exp_cfg;
        lane = -1;
        for (int l = 0; l < num_lanes; l++) begin
            if (lane < 0 && exp_word_q[l].size() > 0 && exp_word_q[l][0] === pkt_word)
                lane = l;
        end
        if (lane < 0)
            lane = int'(pkt_lane);
        if (exp_word_q[lane].size() == 0)
            fail_stop($sformatf("packet arrived on lane %0d with no frame pending there", lane));
        exp_word = exp_word_q[lane].pop_front();
        exp_perr = exp_perr_q[lane].pop_front();
        exp_cfg  = (exp_word.cfg_view.kind == kind_cfg_write) ||
                   (exp_word.cfg_view.kind == kind_cfg_read);
        check_lane("pkt_lane", pkt_lane, lane_idx_bits'(lane));
        check_word("pkt_word", pkt_word, exp_word);
        check_flag("pkt_parity_error", pkt_parity_error, exp_perr);
        check_flag("pkt_is_config", pkt_is_config, exp_cfg);
        if (exp_cfg) begin
            check_field("pkt_timestamp", pkt_timestamp, 32'd0);
            check_field("pkt_reg_addr", 32'(pkt_reg_addr), 32'(exp_word.cfg_view.reg_addr));
            check_field("pkt_reg_value", pkt_reg_value, exp_word.cfg_view.reg_value);
        end else begin
            check_field("pkt_timestamp", pkt_timestamp, exp_word.data_view.timestamp);
            check_field("pkt_reg_addr", 32'(pkt_reg_addr), 32'd0);
            check_field("pkt_reg_value", pkt_reg_value, 32'd0);
        end
    endtask

    // outputs are sampled and inputs driven on the falling edge only
    task automatic tick();
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles)
            fail_stop("timeout, expected packets did not all arrive");
        for (int l = 0; l < num_lanes; l++) begin
            if (lane_fault[l]) begin
                if (!stuck_active[l])
                    fail_stop($sformatf("lane_fault rose on lane %0d which was not held low", l));
                fault_seen[l] = 1'b1;
            end
        end
        if (pkt_valid)
            check_packet();
        for (int l = 0; l < num_lanes; l++) begin
            if (bit_q[l].size() > 0)
                serial_in[l] = bit_q[l].pop_front();
            else
                serial_in[l] = 1'b1;
        end
    endtask

    // 100 low cycles give one all-zero frame with bad parity, then silence
    task automatic hold_low(input int lane);
        stuck_active[lane] = 1'b1;
        fault_seen[lane]   = 1'b0;
        repeat (100) bit_q[lane].push_back(1'b0);
        repeat (4) bit_q[lane].push_back(1'b1);
        exp_word_q[lane].push_back('0);
        exp_perr_q[lane].push_back(1'b1);
        while (bit_q[lane].size() > 0)
            tick();
        if (!fault_seen[lane])
            fail_stop($sformatf("lane_fault never rose on lane %0d while held low", lane));
        check_flag("lane_fault", lane_fault[lane], 1'b0);
        stuck_active[lane] = 1'b0;
    endtask

    function automatic logic all_drained();
        logic done;
        done = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
            if (bit_q[l].size() > 0 || exp_word_q[l].size() > 0)
                done = 1'b0;
        end
        return done;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        packet_word_u word;
        logic [31:0]  r1;
        logic [31:0]  r2;
        logic [31:0]  r3;
        reset_n      = 1'b0;
        serial_in    = '1;
        stuck_active = '0;
        fault_seen   = '0;
        cycle_cnt    = 0;
        rng_state    = 32'd88278;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        check_flag("pkt_valid", pkt_valid, 1'b0);
        for (int l = 0; l < num_lanes; l++) begin
            check_flag("lane_fault", lane_fault[l], 1'b0);
        end
        for (int r = 0; r < num_rows; r++) begin
            repeat (table_rows[r].delay) tick();
            if (table_rows[r].stuck) begin
                hold_low(table_rows[r].lane);
            end else begin
                rng_state = xorshift32(rng_state);
                r1 = rng_state;
                rng_state = xorshift32(rng_state);
                r2 = rng_state;
                rng_state = xorshift32(rng_state);
                r3 = rng_state;
                word = make_word(table_rows[r].kind, r1, r2, r3);
                send_frame(table_rows[r].lane, word, table_rows[r].corrupt);
            end
        end
        while (!all_drained())
            tick();
        // stray packets would show up within one scan
        repeat (2 * num_lanes + 4) tick();
        $display(">>> PASS");
        $finish;
    end

endmodule
